//--- hdl/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Data and address width
`define XLEN 32

// Depth in 32-bit words, byte addresses 0 .. 4*MEM_WORDS-1
`define MEM_WORDS 256

// Cycles from request acceptance to response, 1 or more
`define MEM_LATENCY 2

`endif

//--- hdl/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef enum logic [2:0] {
        OP_LOAD,
        OP_STORE,
        OP_LR,
        OP_SC,
        OP_AMO
    } mem_op_e;

    // Read-modify-write flavours of the A extension
    typedef enum logic [3:0] {
        AMO_SWAP,
        AMO_ADD,
        AMO_XOR,
        AMO_AND,
        AMO_OR,
        AMO_MIN,
        AMO_MAX,
        AMO_MINU,
        AMO_MAXU
    } amo_op_e;

    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W
    } mem_size_e;

    // mcause exception codes
    typedef enum logic [3:0] {
        LOAD_MISALIGNED        = 4'd4,
        LOAD_ACCESS_FAULT      = 4'd5,
        STORE_AMO_MISALIGNED   = 4'd6,
        STORE_AMO_ACCESS_FAULT = 4'd7
    } trap_cause_e;

endpackage

`default_nettype wire

//--- hdl/bus_pkg.sv
`default_nettype none
`include "mem_defines.svh"

package bus_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`XLEN-1:0] addr_t;  // Byte address

    typedef enum logic {
        RESP_OK,
        RESP_ACCESS_FAULT
    } resp_e;

endpackage

`default_nettype wire

//--- hdl/dmem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dmem_if;

    logic           req_valid;
    logic           req_ready;
    logic           req_wen;
    bus_pkg::addr_t req_addr;
    bus_pkg::word_t req_wdata;
    logic [3:0]     req_wmask;   // One bit per byte lane

    // Single-cycle pulse, cannot be stalled
    logic            resp_valid;
    bus_pkg::word_t  resp_rdata;
    bus_pkg::resp_e  resp_status;

    modport master (
        output req_valid, req_wen, req_addr, req_wdata, req_wmask,
        input  req_ready, resp_valid, resp_rdata, resp_status
    );

    modport slave (
        input  req_valid, req_wen, req_addr, req_wdata, req_wmask,
        output req_ready, resp_valid, resp_rdata, resp_status
    );

endinterface

`default_nettype wire

//--- hdl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_defines.svh"

module mem_stage (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      cmd_valid,
    output logic                     cmd_ready,
    input  wire core_pkg::mem_op_e   cmd_op,
    input  wire core_pkg::amo_op_e   cmd_amo,
    input  wire core_pkg::mem_size_e cmd_size,
    input  wire                      cmd_signed,
    input  wire bus_pkg::addr_t      cmd_addr,
    input  wire bus_pkg::word_t      cmd_wdata,
    output logic                     result_valid,
    input  wire                      result_ready,
    output bus_pkg::word_t           result_rdata,
    output logic                     result_trap,
    output core_pkg::trap_cause_e    result_cause,
    dmem_if.master                   bus
);

    typedef enum logic [2:0] {
        IDLE,
        ISSUE,
        WAIT_READ,
        WAIT_WRITE,
        DONE
    } state_e;

    state_e state;

    core_pkg::mem_op_e   op_q;
    core_pkg::amo_op_e   amo_q;
    core_pkg::mem_size_e size_q;
    logic                signed_q;
    bus_pkg::addr_t      addr_q;
    bus_pkg::word_t      wdata_q;

    logic                amo_wr_q;   // AMO in its write phase
    bus_pkg::word_t      amo_old_q;
    logic                resv_valid;
    logic [`XLEN-1:2]    resv_word;

    logic           cmd_fire;
    logic           cmd_misaligned;
    logic           cmd_store_side;
    logic           cmd_sc_fail;
    logic           sc_match;
    logic           op_store_side;
    logic           write_phase;
    logic           resp_fault;
    logic [1:0]     lane;
    logic [3:0]     size_mask;
    logic           amo_lt_s;
    logic           amo_lt_u;
    bus_pkg::word_t load_shift;
    bus_pkg::word_t load_data;
    bus_pkg::word_t amo_new;

    assign cmd_ready    = (state == IDLE);
    assign result_valid = (state == DONE);
    assign cmd_fire     = cmd_valid && cmd_ready;

    // Atomics are word only
    always_comb begin
        case (cmd_size)
            core_pkg::SIZE_B: cmd_misaligned = 1'b0;
            core_pkg::SIZE_H: cmd_misaligned = cmd_addr[0];
            default:          cmd_misaligned = |cmd_addr[1:0];
        endcase
        if (cmd_op != core_pkg::OP_LOAD && cmd_op != core_pkg::OP_STORE &&
            cmd_size != core_pkg::SIZE_W) begin
            cmd_misaligned = 1'b1;
        end
    end

    assign cmd_store_side = cmd_op != core_pkg::OP_LOAD && cmd_op != core_pkg::OP_LR;
    assign op_store_side  = op_q != core_pkg::OP_LOAD && op_q != core_pkg::OP_LR;
    assign sc_match       = resv_valid && resv_word == cmd_addr[`XLEN-1:2];
    assign cmd_sc_fail    = cmd_op == core_pkg::OP_SC && !sc_match;

    assign write_phase = op_q == core_pkg::OP_STORE || op_q == core_pkg::OP_SC ||
                         (op_q == core_pkg::OP_AMO && amo_wr_q);
    assign resp_fault  = bus.resp_status == bus_pkg::RESP_ACCESS_FAULT;
    assign lane        = addr_q[1:0];

    always_comb begin
        case (size_q)
            core_pkg::SIZE_B: size_mask = 4'b0001;
            core_pkg::SIZE_H: size_mask = 4'b0011;
            default:          size_mask = 4'b1111;
        endcase
    end

    // Load lanes back down to bit 0
    assign load_shift = bus.resp_rdata >> {lane, 3'b000};

    always_comb begin
        case (size_q)
            core_pkg::SIZE_B:
                load_data = {{(`XLEN-8){signed_q & load_shift[7]}}, load_shift[7:0]};
            core_pkg::SIZE_H:
                load_data = {{(`XLEN-16){signed_q & load_shift[15]}}, load_shift[15:0]};
            default:
                load_data = load_shift;
        endcase
    end

    assign amo_lt_s = $signed(amo_old_q) < $signed(wdata_q);
    assign amo_lt_u = amo_old_q < wdata_q;

    always_comb begin
        case (amo_q)
            core_pkg::AMO_SWAP: amo_new = wdata_q;
            core_pkg::AMO_ADD:  amo_new = amo_old_q + wdata_q;
            core_pkg::AMO_XOR:  amo_new = amo_old_q ^ wdata_q;
            core_pkg::AMO_AND:  amo_new = amo_old_q & wdata_q;
            core_pkg::AMO_OR:   amo_new = amo_old_q | wdata_q;
            core_pkg::AMO_MIN:  amo_new = amo_lt_s ? amo_old_q : wdata_q;
            core_pkg::AMO_MAX:  amo_new = amo_lt_s ? wdata_q : amo_old_q;
            core_pkg::AMO_MINU: amo_new = amo_lt_u ? amo_old_q : wdata_q;
            core_pkg::AMO_MAXU: amo_new = amo_lt_u ? wdata_q : amo_old_q;
            default:            amo_new = wdata_q;
        endcase
    end

    assign bus.req_valid = (state == ISSUE);
    assign bus.req_wen   = write_phase;
    assign bus.req_addr  = addr_q;
    assign bus.req_wdata = (op_q == core_pkg::OP_AMO) ? amo_new : wdata_q << {lane, 3'b000};
    assign bus.req_wmask = size_mask << lane;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            amo_wr_q   <= 1'b0;
            resv_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_fire) begin
                        amo_wr_q <= 1'b0;
                        if (cmd_op == core_pkg::OP_SC) begin
                            resv_valid <= 1'b0;  // Consumed on success or failure
                        end
                        state <= (cmd_misaligned || cmd_sc_fail) ? DONE : ISSUE;
                    end
                end
                ISSUE: begin
                    if (bus.req_ready) begin
                        state <= write_phase ? WAIT_WRITE : WAIT_READ;
                    end
                end
                WAIT_READ: begin
                    if (bus.resp_valid) begin
                        if (!resp_fault && op_q == core_pkg::OP_AMO) begin
                            amo_wr_q <= 1'b1;
                            state    <= ISSUE;
                        end else begin
                            state <= DONE;
                        end
                        if (!resp_fault && op_q == core_pkg::OP_LR) begin
                            resv_valid <= 1'b1;
                        end
                    end
                end
                WAIT_WRITE: begin
                    if (bus.resp_valid) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (result_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (cmd_fire) begin
                    op_q         <= cmd_op;
                    amo_q        <= cmd_amo;
                    size_q       <= cmd_size;
                    signed_q     <= cmd_signed;
                    addr_q       <= cmd_addr;
                    wdata_q      <= cmd_wdata;
                    result_trap  <= cmd_misaligned;
                    result_cause <= cmd_store_side ? core_pkg::STORE_AMO_MISALIGNED
                                                   : core_pkg::LOAD_MISALIGNED;
                    // SC failure code is 1, everything else starts at 0
                    result_rdata <= {{(`XLEN-1){1'b0}}, cmd_sc_fail && !cmd_misaligned};
                end
            end
            WAIT_READ: begin
                if (bus.resp_valid) begin
                    amo_old_q    <= bus.resp_rdata;
                    result_trap  <= resp_fault;
                    result_cause <= op_store_side ? core_pkg::STORE_AMO_ACCESS_FAULT
                                                  : core_pkg::LOAD_ACCESS_FAULT;
                    result_rdata <= resp_fault ? '0 : load_data;
                    if (!resp_fault && op_q == core_pkg::OP_LR) begin
                        resv_word <= addr_q[`XLEN-1:2];
                    end
                end
            end
            WAIT_WRITE: begin
                if (bus.resp_valid) begin
                    result_trap  <= resp_fault;
                    result_cause <= core_pkg::STORE_AMO_ACCESS_FAULT;
                    if (resp_fault) begin
                        result_rdata <= '0;
                    end
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/data_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_defines.svh"

module data_ram (
    input wire    clk,
    input wire    rst_n,
    dmem_if.slave bus
);

    localparam int LAT    = `MEM_LATENCY;
    localparam int NBYTES = `XLEN / 8;
    localparam int IDX_W  = $clog2(`MEM_WORDS);

    bus_pkg::word_t mem [`MEM_WORDS];

    // Response pipeline, stage LAT-1 drives the bus
    logic [LAT-1:0] pend_valid;
    logic [LAT-1:0] pend_fault;
    bus_pkg::word_t pend_rdata [LAT];

    logic             accept;
    logic             in_range;
    logic [IDX_W-1:0] word_idx;
    bus_pkg::word_t   rd_word;

    assign accept   = bus.req_valid && bus.req_ready;
    assign in_range = bus.req_addr < bus_pkg::addr_t'(4 * `MEM_WORDS);
    assign word_idx = bus.req_addr[IDX_W+1:2];
    assign rd_word  = in_range ? mem[word_idx] : '0;

    // One request in flight at a time
    assign bus.req_ready = ~|pend_valid;

    always_ff @(posedge clk) begin
        if (accept && bus.req_wen && in_range) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (bus.req_wmask[b]) begin
                    mem[word_idx][8*b +: 8] <= bus.req_wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_valid <= '0;
        end else begin
            pend_valid[0] <= accept;
            for (int i = 1; i < LAT; i++) begin
                pend_valid[i] <= pend_valid[i-1];
            end
        end
    end

    // Payload moves in step with pend_valid
    always_ff @(posedge clk) begin
        pend_rdata[0] <= rd_word;   // Old word, before this edge's write
        pend_fault[0] <= !in_range;
        for (int i = 1; i < LAT; i++) begin
            pend_rdata[i] <= pend_rdata[i-1];
            pend_fault[i] <= pend_fault[i-1];
        end
    end

    assign bus.resp_valid  = pend_valid[LAT-1];
    assign bus.resp_rdata  = pend_rdata[LAT-1];
    assign bus.resp_status = pend_fault[LAT-1] ? bus_pkg::RESP_ACCESS_FAULT : bus_pkg::RESP_OK;

endmodule

`default_nettype wire

//--- hdl/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      cmd_valid,
    output logic                     cmd_ready,
    input  wire core_pkg::mem_op_e   cmd_op,
    input  wire core_pkg::amo_op_e   cmd_amo,
    input  wire core_pkg::mem_size_e cmd_size,
    input  wire                      cmd_signed,
    input  wire bus_pkg::addr_t      cmd_addr,
    input  wire bus_pkg::word_t      cmd_wdata,
    output logic                     result_valid,
    input  wire                      result_ready,
    output bus_pkg::word_t           result_rdata,
    output logic                     result_trap,
    output core_pkg::trap_cause_e    result_cause
);

    dmem_if dbus ();

    mem_stage u_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_op       (cmd_op),
        .cmd_amo      (cmd_amo),
        .cmd_size     (cmd_size),
        .cmd_signed   (cmd_signed),
        .cmd_addr     (cmd_addr),
        .cmd_wdata    (cmd_wdata),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_rdata (result_rdata),
        .result_trap  (result_trap),
        .result_cause (result_cause),
        .bus          (dbus.master)
    );

    // Fixed-latency data memory
    data_ram u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (dbus.slave)
    );

endmodule

`default_nettype wire

//--- test/tb_mem_tasks.svh
`ifndef TB_MEM_TASKS_SVH
`define TB_MEM_TASKS_SVH

task automatic check_value(
    input string            name,
    input string            what,
    input logic [`XLEN-1:0] exp,
    input logic [`XLEN-1:0] act
);
    assert (exp === act) else begin
        $display("[ERROR] %s: %s expected %h, actual %h", name, what, exp, act);
        stop_on_error();
    end
endtask

// Called and returns 1 ns after a rising edge
task automatic run_cmd(
    input string                 name,
    input core_pkg::mem_op_e     op,
    input core_pkg::amo_op_e     amo,
    input core_pkg::mem_size_e   size,
    input logic                  sgn,
    input logic [`XLEN-1:0]      addr,
    input logic [`XLEN-1:0]      wdata,
    input logic [`XLEN-1:0]      exp_rdata,
    input logic                  exp_trap,
    input core_pkg::trap_cause_e exp_cause,
    input int                    stall
);
    logic [`XLEN-1:0] held_rdata;
    logic [4:0]       held_info;   // Trap flag over cause
    cmd_valid  = 1'b1;
    cmd_op     = op;
    cmd_amo    = amo;
    cmd_size   = size;
    cmd_signed = sgn;
    cmd_addr   = addr;
    cmd_wdata  = wdata;
    while (!cmd_ready) begin
        @(posedge clk);
        #1;
    end
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    while (!result_valid) begin
        @(posedge clk);
        #1;
    end
    check_value(name, "trap", `XLEN'(exp_trap), `XLEN'(result_trap));
    check_value(name, "rdata", exp_rdata, result_rdata);
    if (exp_trap) begin
        check_value(name, "cause", `XLEN'(exp_cause), `XLEN'(result_cause));
    end
    held_rdata = result_rdata;
    held_info  = {result_trap, result_cause};
    repeat (stall) begin
        @(posedge clk);
        #1;
        check_value(name, "valid and cmd_ready", 32'd2, `XLEN'({result_valid, cmd_ready}));
        check_value(name, "held rdata", held_rdata, result_rdata);
        check_value(name, "held trap and cause", `XLEN'(held_info),
                    `XLEN'({result_trap, result_cause}));
    end
    result_ready = 1'b1;
    @(posedge clk);
    #1;
    result_ready = 1'b0;
endtask

task automatic do_store(input string name, input core_pkg::mem_size_e size,
                        input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data,
                        input int stall);
    run_cmd(name, core_pkg::OP_STORE, core_pkg::AMO_SWAP, size, 1'b0, addr, data,
            '0, 1'b0, core_pkg::LOAD_MISALIGNED, stall);
    shadow_write(size, addr, data);
endtask

task automatic do_load(input string name, input core_pkg::mem_size_e size, input logic sgn,
                       input logic [`XLEN-1:0] addr, input int stall);
    run_cmd(name, core_pkg::OP_LOAD, core_pkg::AMO_SWAP, size, sgn, addr, '0,
            shadow_read(size, sgn, addr), 1'b0, core_pkg::LOAD_MISALIGNED, stall);
endtask

task automatic do_atomic(input string name, input core_pkg::mem_op_e op,
                         input core_pkg::amo_op_e amo, input logic [`XLEN-1:0] addr,
                         input logic [`XLEN-1:0] wdata, input logic [`XLEN-1:0] exp);
    run_cmd(name, op, amo, core_pkg::SIZE_W, 1'b0, addr, wdata, exp, 1'b0,
            core_pkg::LOAD_MISALIGNED, 0);
endtask

task automatic do_trap(input string name, input core_pkg::mem_op_e op,
                       input core_pkg::mem_size_e size, input logic [`XLEN-1:0] addr,
                       input core_pkg::trap_cause_e cause);
    run_cmd(name, op, core_pkg::AMO_ADD, size, 1'b0, addr, 32'hFFFF_FFFF, '0, 1'b1, cause, 0);
endtask

task automatic amo_round(input core_pkg::amo_op_e op, input logic [`XLEN-1:0] old,
                         input logic [`XLEN-1:0] opnd);
    do_store("amo setup", core_pkg::SIZE_W, 32'h300, old, 0);
    do_atomic($sformatf("amo %s", op.name()), core_pkg::OP_AMO, op, 32'h300, opnd, old);
    shadow_write(core_pkg::SIZE_W, 32'h300, amo_result(op, old, opnd));
    do_load($sformatf("load after %s", op.name()), core_pkg::SIZE_W, 1'b0, 32'h300, 0);
endtask

task automatic test_load_store();
    logic [`XLEN-1:0] base;
    logic [`XLEN-1:0] data;
    check_value("reset", "valid and cmd_ready", 32'd1, `XLEN'({result_valid, cmd_ready}));
    for (int w = 0; w < `MEM_WORDS; w++) begin
        base = `XLEN'(4 * w);
        do_store("fill", core_pkg::SIZE_W, base, {~base[15:0], base[15:0]}, 0);
    end
    base = 32'h100;
    for (int i = 0; i < 4; i++) begin
        data    = $random(seed);
        data[7] = ~i[0];  // Top bit set on even lanes
        do_store("store byte", core_pkg::SIZE_B, base + `XLEN'(i), data, 0);
        do_load("load byte signed", core_pkg::SIZE_B, 1'b1, base + `XLEN'(i), 0);
        do_load("load byte unsigned", core_pkg::SIZE_B, 1'b0, base + `XLEN'(i), 0);
    end
    for (int i = 0; i < 4; i += 2) begin
        data     = $random(seed);
        data[15] = ~i[1];
        do_store("store half", core_pkg::SIZE_H, base + `XLEN'(i), data, 0);
        do_load("load half signed", core_pkg::SIZE_H, 1'b1, base + `XLEN'(i), 0);
        do_load("load half unsigned", core_pkg::SIZE_H, 1'b0, base + `XLEN'(i), 0);
    end
    do_store("store word", core_pkg::SIZE_W, base + 32'd8, $random(seed), 0);
    do_load("load word", core_pkg::SIZE_W, 1'b0, base + 32'd8, 0);
endtask

task automatic test_reservation();
    logic [`XLEN-1:0] base;
    logic [`XLEN-1:0] data;
    base = 32'h200;
    data = $random(seed);
    do_atomic("lr", core_pkg::OP_LR, core_pkg::AMO_SWAP, base, '0,
              shadow_read(core_pkg::SIZE_W, 1'b0, base));
    do_atomic("sc after lr", core_pkg::OP_SC, core_pkg::AMO_SWAP, base, data, 32'd0);
    shadow_write(core_pkg::SIZE_W, base, data);
    do_load("load after sc", core_pkg::SIZE_W, 1'b0, base, 0);
    do_atomic("second sc", core_pkg::OP_SC, core_pkg::AMO_SWAP, base, ~data, 32'd1);
    do_load("load after failed sc", core_pkg::SIZE_W, 1'b0, base, 0);
    do_atomic("lr again", core_pkg::OP_LR, core_pkg::AMO_SWAP, base, '0, data);
    do_atomic("sc other word", core_pkg::OP_SC, core_pkg::AMO_SWAP, base + 32'd4, ~data, 32'd1);
    do_load("load other word", core_pkg::SIZE_W, 1'b0, base + 32'd4, 0);
endtask

task automatic test_amo();
    // Negative old word against a positive operand
    for (int i = 0; i < 9; i++) begin
        amo_round(core_pkg::amo_op_e'(i[3:0]), $random(seed) | 32'h8000_0000,
                  $random(seed) & 32'h7FFF_FFFF);
    end
    for (int i = 5; i < 9; i++) begin  // Compares again with the signs swapped
        amo_round(core_pkg::amo_op_e'(i[3:0]), $random(seed) & 32'h7FFF_FFFF,
                  $random(seed) | 32'h8000_0000);
    end
endtask

task automatic test_access_fault();
    do_trap("load fault", core_pkg::OP_LOAD, core_pkg::SIZE_W, `XLEN'(BYTES),
            core_pkg::LOAD_ACCESS_FAULT);
    do_trap("load byte fault", core_pkg::OP_LOAD, core_pkg::SIZE_B, `XLEN'(BYTES + 1),
            core_pkg::LOAD_ACCESS_FAULT);
    do_trap("lr fault", core_pkg::OP_LR, core_pkg::SIZE_W, `XLEN'(BYTES + 4),
            core_pkg::LOAD_ACCESS_FAULT);
    do_trap("store fault", core_pkg::OP_STORE, core_pkg::SIZE_W, 32'h8000_0000,
            core_pkg::STORE_AMO_ACCESS_FAULT);
    do_trap("store half fault", core_pkg::OP_STORE, core_pkg::SIZE_H, `XLEN'(BYTES + 2),
            core_pkg::STORE_AMO_ACCESS_FAULT);
    do_trap("amo fault", core_pkg::OP_AMO, core_pkg::SIZE_W, `XLEN'(BYTES + 8),
            core_pkg::STORE_AMO_ACCESS_FAULT);
    // No LR can reserve a word outside the memory, so this SC fails before the bus
    do_atomic("sc outside memory", core_pkg::OP_SC, core_pkg::AMO_SWAP, `XLEN'(BYTES + 12),
              32'h1234_5678, 32'd1);
    do_load("load after faults", core_pkg::SIZE_W, 1'b0, 32'h0, 0);
endtask

task automatic test_misaligned();
    logic [`XLEN-1:0] base;
    base = 32'h340;
    do_trap("sh +1", core_pkg::OP_STORE, core_pkg::SIZE_H, base + 32'd1,
            core_pkg::STORE_AMO_MISALIGNED);
    do_trap("sh +3", core_pkg::OP_STORE, core_pkg::SIZE_H, base + 32'd3,
            core_pkg::STORE_AMO_MISALIGNED);
    for (int i = 1; i < 4; i++) begin
        do_trap("sw misaligned", core_pkg::OP_STORE, core_pkg::SIZE_W, base + `XLEN'(i),
                core_pkg::STORE_AMO_MISALIGNED);
    end
    do_trap("lh +1", core_pkg::OP_LOAD, core_pkg::SIZE_H, base + 32'd1,
            core_pkg::LOAD_MISALIGNED);
    do_trap("lw +2", core_pkg::OP_LOAD, core_pkg::SIZE_W, base + 32'd2,
            core_pkg::LOAD_MISALIGNED);
    do_trap("lr +2", core_pkg::OP_LR, core_pkg::SIZE_W, base + 32'd2,
            core_pkg::LOAD_MISALIGNED);
    do_trap("sc +1", core_pkg::OP_SC, core_pkg::SIZE_W, base + 32'd1,
            core_pkg::STORE_AMO_MISALIGNED);
    do_trap("amo +2", core_pkg::OP_AMO, core_pkg::SIZE_W, base + 32'd2,
            core_pkg::STORE_AMO_MISALIGNED);
    do_trap("amo half size", core_pkg::OP_AMO, core_pkg::SIZE_H, base,
            core_pkg::STORE_AMO_MISALIGNED);
    do_load("target word unchanged", core_pkg::SIZE_W, 1'b0, base, 0);
    do_load("next word unchanged", core_pkg::SIZE_W, 1'b0, base + 32'd4, 0);
endtask

task automatic test_back_pressure();
    for (int i = 0; i < 4; i++) begin
        do_store("stalled store", core_pkg::SIZE_W, 32'h380 + `XLEN'(4 * i), $random(seed),
                 $random(seed) & 15);
        do_load("stalled load", core_pkg::SIZE_H, 1'b1, 32'h382 + `XLEN'(4 * i),
                $random(seed) & 15);
    end
    // Each command enters in the cycle after the previous result transfer
    do_store("back-to-back byte", core_pkg::SIZE_B, 32'h3A1, $random(seed), 0);
    do_load("back-to-back load", core_pkg::SIZE_B, 1'b0, 32'h3A1, 0);
    do_store("back-to-back half", core_pkg::SIZE_H, 32'h3A2, $random(seed), 0);
    amo_round(core_pkg::AMO_ADD, $random(seed), $random(seed));
endtask

`endif

//--- test/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_defines.svh"

module tb_mem_subsys;

    localparam int BYTES = 4 * `MEM_WORDS;
    localparam int BW    = $clog2(BYTES);
    // Fill, load/store, reservation, AMO, fault, misaligned, back-pressure
    localparam int N_CMDS  = `MEM_WORDS + 20 + 8 + 39 + 8 + 13 + 14;
    localparam int TIMEOUT = 200 * N_CMDS + 10;

    logic                  clk;
    logic                  rst_n;
    logic                  cmd_valid;
    logic                  cmd_ready;
    core_pkg::mem_op_e     cmd_op;
    core_pkg::amo_op_e     cmd_amo;
    core_pkg::mem_size_e   cmd_size;
    logic                  cmd_signed;
    logic [`XLEN-1:0]      cmd_addr;
    logic [`XLEN-1:0]      cmd_wdata;
    logic                  result_valid;
    logic                  result_ready;
    logic [`XLEN-1:0]      result_rdata;
    logic                  result_trap;
    core_pkg::trap_cause_e result_cause;

    integer     seed;
    logic [7:0] shadow [BYTES];  // Reference copy of the memory bytes

    mem_subsys_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_op       (cmd_op),
        .cmd_amo      (cmd_amo),
        .cmd_size     (cmd_size),
        .cmd_signed   (cmd_signed),
        .cmd_addr     (cmd_addr),
        .cmd_wdata    (cmd_wdata),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_rdata (result_rdata),
        .result_trap  (result_trap),
        .result_cause (result_cause)
    );

    function automatic int size_bytes(input core_pkg::mem_size_e size);
        return (size == core_pkg::SIZE_B) ? 1 : (size == core_pkg::SIZE_H) ? 2 : 4;
    endfunction

    function automatic logic [BW-1:0] byte_idx(input logic [`XLEN-1:0] addr, input int offs);
        logic [`XLEN-1:0] a;
        a = addr + `XLEN'(offs);
        return a[BW-1:0];
    endfunction

    task automatic shadow_write(
        input core_pkg::mem_size_e size,
        input logic [`XLEN-1:0]    addr,
        input logic [`XLEN-1:0]    data
    );
        for (int i = 0; i < size_bytes(size); i++) begin
            shadow[byte_idx(addr, i)] = data[8*i +: 8];  // Little endian
        end
    endtask

    function automatic logic [`XLEN-1:0] shadow_read(
        input core_pkg::mem_size_e size,
        input logic                sgn,
        input logic [`XLEN-1:0]    addr
    );
        logic [`XLEN-1:0] val;
        int               nb;
        nb  = size_bytes(size);
        val = '0;
        for (int i = 0; i < nb; i++) begin
            val[8*i +: 8] = shadow[byte_idx(addr, i)];
        end
        if (sgn && val[8*nb-1]) begin
            val = val | ~((`XLEN'(1) << (8*nb)) - `XLEN'(1));
        end
        return val;
    endfunction

    // New memory word of an AMO
    function automatic logic [`XLEN-1:0] amo_result(
        input core_pkg::amo_op_e op,
        input logic [`XLEN-1:0]  old,
        input logic [`XLEN-1:0]  opnd
    );
        case (op)
            core_pkg::AMO_SWAP: return opnd;
            core_pkg::AMO_ADD:  return old + opnd;
            core_pkg::AMO_XOR:  return old ^ opnd;
            core_pkg::AMO_AND:  return old & opnd;
            core_pkg::AMO_OR:   return old | opnd;
            core_pkg::AMO_MIN:  return ($signed(old) < $signed(opnd)) ? old : opnd;
            core_pkg::AMO_MAX:  return ($signed(old) > $signed(opnd)) ? old : opnd;
            core_pkg::AMO_MINU: return (old < opnd) ? old : opnd;
            default:            return (old > opnd) ? old : opnd;
        endcase
    endfunction

    task automatic stop_on_error();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    `include "tb_mem_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
        stop_on_error();
    end

    initial begin
        seed         = 44108;
        rst_n        = 1'b0;
        cmd_valid    = 1'b0;
        cmd_op       = core_pkg::OP_LOAD;
        cmd_amo      = core_pkg::AMO_SWAP;
        cmd_size     = core_pkg::SIZE_W;
        cmd_signed   = 1'b0;
        cmd_addr     = '0;
        cmd_wdata    = '0;
        result_ready = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_load_store();
        test_reservation();
        test_amo();
        test_access_fault();
        test_misaligned();
        test_back_pressure();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
+incdir+test
hdl/core_pkg.sv
hdl/bus_pkg.sv
hdl/dmem_if.sv
hdl/mem_stage.sv
hdl/data_ram.sv
hdl/mem_subsys_top.sv
test/tb_mem_subsys.sv

//--- Makefile
TOOL     ?= verilator
FLAGS    ?= --timing --assert --timescale 1ns/1ps
TOP      ?= tb_mem_subsys
FILELIST ?= files.f
OBJ_DIR  ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The binary exits non-zero on $$fatal, so make reports the failure
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
